//--- rv_core_pkg.sv
// Shared widths, opcodes and constants for the RV32I core, referenced by scoped names
package rv_core_pkg;

  localparam int XLEN = 32;                   // Integer register width

  typedef logic [XLEN-1:0] xlen_t;            // Register value or ALU result
  typedef logic [31:0]     addr_t;            // Byte address, PC and targets
  typedef logic [31:0]     instr_t;           // Raw instruction word
  typedef logic [4:0]      reg_idx_t;         // Register index x0..x31
  typedef logic [1:0]      br_kind_t;         // Control transfer kind

  // ALU operations, PASS_B serves LUI
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  ////////////////////////////////////////
  // Control transfer kinds
  localparam br_kind_t BR_NONE = 2'd0;
  localparam br_kind_t BR_EQ   = 2'd1;
  localparam br_kind_t BR_NE   = 2'd2;
  localparam br_kind_t BR_JAL  = 2'd3;

  localparam addr_t  BOOT_ADDR = 32'h0000_0000;  // Reset PC
  localparam instr_t NOP_INSTR = 32'h0000_0013;  // ADDI x0,x0,0

  ////////////////////////////////////////
  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 values, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;  // Branch compares
  localparam logic [2:0] F3_BNE = 3'b001;

endpackage

//--- rv_fetch.sv
// Instruction fetch stage for a synchronous memory with one cycle of read delay, feeds decode
`timescale 1ns/100ps

module rv_fetch (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                redirect_i,     // One cycle pulse from execute
  input  rv_core_pkg::addr_t  redirect_pc_i,
  input  logic                dec_ready_i,
  output rv_core_pkg::addr_t  imem_addr_o,
  input  rv_core_pkg::instr_t imem_rdata_i,   // Word for last cycle's address
  output rv_core_pkg::instr_t instr_o,
  output rv_core_pkg::addr_t  pc_o,
  output logic                valid_o
);

  rv_core_pkg::addr_t  pc_q;       // Address on the memory port
  rv_core_pkg::instr_t save_q;     // Word caught on the first stall cycle
  rv_core_pkg::instr_t word;       // Word for pc_q - 4
  logic                stall_q;    // Previous cycle was stalled
  logic [1:0]          vld_sr_q;   // [0] word in flight, [1] output valid

  assign imem_addr_o = pc_q;
  assign valid_o     = vld_sr_q[1];

  // Memory already moved on to pc_q after a stall, so use the saved copy
  assign word = stall_q ? save_q : imem_rdata_i;

  ////////////////////////////////////////
  // Program counter
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pc_q <= rv_core_pkg::BOOT_ADDR;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;            // Taken even while decode stalls
    end else if (dec_ready_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  ////////////////////////////////////////
  // Valid shift register
  // Clearing it drops the two words already requested on the old path
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      vld_sr_q <= 2'b00;
    end else if (redirect_i) begin
      vld_sr_q <= 2'b00;
    end else if (dec_ready_i) begin
      vld_sr_q <= {vld_sr_q[0], 1'b1};  // New request issued every accepted cycle
    end
  end

  // Output register toward decode
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_o <= rv_core_pkg::NOP_INSTR;
      pc_o    <= rv_core_pkg::BOOT_ADDR;
    end else if (dec_ready_i && vld_sr_q[0] && !redirect_i) begin
      instr_o <= word;
      pc_o    <= pc_q - 32'd4;          // Address that produced this word
    end
  end

  ////////////////////////////////////////
  // Stall save
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= !dec_ready_i;
    end
  end

  // Only the first stall cycle carries the word for pc_q - 4
  always_ff @(posedge clk_i) begin
    if (!dec_ready_i && !stall_q) begin
      save_q <= imem_rdata_i;
    end
  end

endmodule

//--- rv_decode.sv
// Decode stage: field split, immediates, register read, hazard interlock and the execute register
`timescale 1ns/100ps

module rv_decode (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   hold_i,        // External back-pressure
  input  rv_core_pkg::instr_t    instr_i,
  input  rv_core_pkg::addr_t     pc_i,
  input  logic                   valid_i,
  output logic                   dec_ready_o,
  output rv_core_pkg::reg_idx_t  rs1_o,
  output rv_core_pkg::reg_idx_t  rs2_o,
  input  rv_core_pkg::xlen_t     rs1_data_i,
  input  rv_core_pkg::xlen_t     rs2_data_i,
  input  rv_core_pkg::reg_idx_t  ex_busy_rd_i,  // Pending write in execute
  input  logic                   ex_busy_i,
  input  rv_core_pkg::reg_idx_t  wb_busy_rd_i,  // Pending write in result
  input  logic                   wb_busy_i,
  input  logic                   flush_i,       // Redirect from execute
  output logic                   ex_valid_o,
  output rv_core_pkg::alu_op_e   alu_op_o,
  output rv_core_pkg::xlen_t     opa_o,
  output rv_core_pkg::xlen_t     opb_o,
  output rv_core_pkg::xlen_t     imm_o,
  output rv_core_pkg::reg_idx_t  rd_o,
  output logic                   rd_we_o,
  output rv_core_pkg::br_kind_t  br_kind_o,
  output rv_core_pkg::addr_t     pc_o
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_core_pkg::xlen_t    imm_i, imm_u, imm_b, imm_j;
  rv_core_pkg::xlen_t    imm_sel;
  rv_core_pkg::alu_op_e  f3_op, alu_op;
  rv_core_pkg::br_kind_t br_kind;
  logic                  f3_ok;          // funct3 is one of the supported ALU ops
  logic                  use_rs1, use_rs2, we;
  logic                  hit1, hit2, hazard, issue;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  // Sign-extended immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      rv_core_pkg::F3_ADD: f3_op = rv_core_pkg::ALU_ADD;
      rv_core_pkg::F3_SLT: f3_op = rv_core_pkg::ALU_SLT;
      rv_core_pkg::F3_XOR: f3_op = rv_core_pkg::ALU_XOR;
      rv_core_pkg::F3_OR:  f3_op = rv_core_pkg::ALU_OR;
      rv_core_pkg::F3_AND: f3_op = rv_core_pkg::ALU_AND;
      default: begin
        f3_op = rv_core_pkg::ALU_ADD;
        f3_ok = 1'b0;                   // Shifts and SLTU fall to NOP
      end
    endcase
  end

  ////////////////////////////////////////
  // Main decode, anything unknown stays a NOP
  always_comb begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    we      = 1'b0;
    alu_op  = rv_core_pkg::ALU_ADD;
    br_kind = rv_core_pkg::BR_NONE;
    imm_sel = imm_i;
    case (opcode)
      rv_core_pkg::OPC_OPIMM: begin
        use_rs1 = f3_ok;
        we      = f3_ok;
        alu_op  = f3_op;
      end
      rv_core_pkg::OPC_OP: begin
        if (f3_ok && (funct7 == 7'b0 ||
                      (funct7 == 7'b0100000 && funct3 == rv_core_pkg::F3_ADD))) begin
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          we      = 1'b1;
          alu_op  = funct7[5] ? rv_core_pkg::ALU_SUB : f3_op;
        end
      end
      rv_core_pkg::OPC_LUI: begin
        we      = 1'b1;
        alu_op  = rv_core_pkg::ALU_PASS_B;
        imm_sel = imm_u;
      end
      rv_core_pkg::OPC_JAL: begin
        we      = 1'b1;
        br_kind = rv_core_pkg::BR_JAL;
        imm_sel = imm_j;
      end
      rv_core_pkg::OPC_BRANCH: begin
        imm_sel = imm_b;
        if (funct3 == rv_core_pkg::F3_BEQ || funct3 == rv_core_pkg::F3_BNE) begin
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          br_kind = (funct3 == rv_core_pkg::F3_BEQ) ? rv_core_pkg::BR_EQ : rv_core_pkg::BR_NE;
        end
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Interlock, the register file has no write bypass so both stages count
  assign hit1 = use_rs1 && (rs1_o != 5'd0) &&
                ((ex_busy_i && ex_busy_rd_i == rs1_o) || (wb_busy_i && wb_busy_rd_i == rs1_o));
  assign hit2 = use_rs2 && (rs2_o != 5'd0) &&
                ((ex_busy_i && ex_busy_rd_i == rs2_o) || (wb_busy_i && wb_busy_rd_i == rs2_o));
  assign hazard      = valid_i && (hit1 || hit2);
  assign dec_ready_o = !hold_i && !hazard;
  assign issue       = valid_i && dec_ready_o && !flush_i;  // Else a bubble goes out

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= issue;              // Flush squashes the word behind the branch
    end
  end

  // Execute payload
  always_ff @(posedge clk_i) begin
    if (issue) begin
      alu_op_o  <= alu_op;
      opa_o     <= rs1_data_i;
      opb_o     <= use_rs2 ? rs2_data_i : imm_sel;
      imm_o     <= imm_sel;
      rd_o      <= instr_i[11:7];
      rd_we_o   <= we;
      br_kind_o <= br_kind;
      pc_o      <= pc_i;
    end
  end

endmodule

//--- rv_execute.sv
// Execute stage: ALU, branch resolve and redirect, registers the result for write-back
`timescale 1ns/100ps

module rv_execute (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  ex_valid_i,
  input  rv_core_pkg::alu_op_e  alu_op_i,
  input  rv_core_pkg::xlen_t    opa_i,
  input  rv_core_pkg::xlen_t    opb_i,
  input  rv_core_pkg::xlen_t    imm_i,
  input  rv_core_pkg::reg_idx_t rd_i,
  input  logic                  rd_we_i,
  input  rv_core_pkg::br_kind_t br_kind_i,
  input  rv_core_pkg::addr_t    pc_i,
  output logic                  redirect_o,     // Single cycle, next cycle holds a bubble
  output rv_core_pkg::addr_t    redirect_pc_o,
  output logic                  busy_o,         // Valid instruction here writes rd
  output rv_core_pkg::reg_idx_t busy_rd_o,
  output logic                  wb_valid_o,
  output rv_core_pkg::reg_idx_t wb_rd_o,
  output logic                  wb_we_o,
  output rv_core_pkg::xlen_t    wb_data_o,
  output rv_core_pkg::addr_t    wb_pc_o
);

  rv_core_pkg::xlen_t alu_res;
  rv_core_pkg::xlen_t result;
  logic               taken;

  ////////////////////////////////////////
  // ALU
  always_comb begin
    case (alu_op_i)
      rv_core_pkg::ALU_ADD:    alu_res = opa_i + opb_i;
      rv_core_pkg::ALU_SUB:    alu_res = opa_i - opb_i;
      rv_core_pkg::ALU_AND:    alu_res = opa_i & opb_i;
      rv_core_pkg::ALU_OR:     alu_res = opa_i | opb_i;
      rv_core_pkg::ALU_XOR:    alu_res = opa_i ^ opb_i;
      rv_core_pkg::ALU_SLT:    alu_res = rv_core_pkg::xlen_t'($signed(opa_i) < $signed(opb_i));
      rv_core_pkg::ALU_PASS_B: alu_res = opb_i;   // LUI
      default:                 alu_res = '0;
    endcase
  end

  // JAL links the next sequential address
  assign result = (br_kind_i == rv_core_pkg::BR_JAL) ? pc_i + 32'd4 : alu_res;

  // Branch resolve
  always_comb begin
    case (br_kind_i)
      rv_core_pkg::BR_EQ:  taken = (opa_i == opb_i);
      rv_core_pkg::BR_NE:  taken = (opa_i != opb_i);
      rv_core_pkg::BR_JAL: taken = 1'b1;
      default:             taken = 1'b0;
    endcase
  end

  assign redirect_o    = ex_valid_i && taken;
  assign redirect_pc_o = pc_i + imm_i;              // B or J offset from decode

  // Pending write for the decode interlock
  assign busy_o    = ex_valid_i && rd_we_i && (rd_i != 5'd0);
  assign busy_rd_o = rd_i;

  ////////////////////////////////////////
  // Write-back register
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      wb_rd_o   <= rd_i;
      wb_we_o   <= rd_we_i;
      wb_data_o <= result;
      wb_pc_o   <= pc_i;
    end
  end

endmodule

//--- rv_result.sv
// Result stage: register file with write-back and the retire report of each instruction
`timescale 1ns/100ps

module rv_result (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  wb_valid_i,
  input  rv_core_pkg::reg_idx_t wb_rd_i,
  input  logic                  wb_we_i,
  input  rv_core_pkg::xlen_t    wb_data_i,
  input  rv_core_pkg::addr_t    wb_pc_i,
  input  rv_core_pkg::reg_idx_t rs1_i,
  input  rv_core_pkg::reg_idx_t rs2_i,
  output rv_core_pkg::xlen_t    rs1_data_o,     // Combinational read
  output rv_core_pkg::xlen_t    rs2_data_o,
  output logic                  busy_o,         // Write lands on this edge
  output rv_core_pkg::reg_idx_t busy_rd_o,
  output logic                  retire_valid_o,
  output rv_core_pkg::addr_t    retire_pc_o,
  output rv_core_pkg::reg_idx_t retire_rd_o,
  output rv_core_pkg::xlen_t    retire_data_o
);

  rv_core_pkg::xlen_t rf_q [32];
  logic               wr_en;

  // x0 is never written
  assign wr_en = wb_valid_i && wb_we_i && (wb_rd_i != 5'd0);

  ////////////////////////////////////////
  // Register file, cleared on reset
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wr_en) begin
      rf_q[wb_rd_i] <= wb_data_i;
    end
  end

  // No bypass of the write in flight
  assign rs1_data_o = (rs1_i == 5'd0) ? '0 : rf_q[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? '0 : rf_q[rs2_i];

  assign busy_o    = wr_en;
  assign busy_rd_o = wb_rd_i;

  // Retire report, same cycle as the write
  assign retire_valid_o = wb_valid_i;
  assign retire_pc_o    = wb_pc_i;
  assign retire_rd_o    = wr_en ? wb_rd_i : 5'd0;
  assign retire_data_o  = wr_en ? wb_data_i : '0;   // Zero for branches and x0

endmodule

//--- rv_core_top.sv
// Core top level: fetch, decode, execute and result with the instruction memory and hold ports
`timescale 1ns/100ps

module rv_core_top (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  hold_i,
  output rv_core_pkg::addr_t    imem_addr_o,
  input  rv_core_pkg::instr_t   imem_rdata_i,
  output logic                  retire_valid_o,
  output rv_core_pkg::addr_t    retire_pc_o,
  output rv_core_pkg::reg_idx_t retire_rd_o,
  output rv_core_pkg::xlen_t    retire_data_o
);

  // Fetch to decode
  rv_core_pkg::instr_t   f_instr;
  rv_core_pkg::addr_t    f_pc;
  logic                  f_valid, dec_ready;
  // Register file reads
  rv_core_pkg::reg_idx_t rs1, rs2;
  rv_core_pkg::xlen_t    rs1_data, rs2_data;
  // Interlock and redirect
  logic                  ex_busy, wb_busy, redirect;
  rv_core_pkg::reg_idx_t ex_busy_rd, wb_busy_rd;
  rv_core_pkg::addr_t    redirect_pc;
  // Decode to execute
  logic                  ex_valid, ex_rd_we;
  rv_core_pkg::alu_op_e  ex_alu_op;
  rv_core_pkg::xlen_t    ex_opa, ex_opb, ex_imm;
  rv_core_pkg::reg_idx_t ex_rd;
  rv_core_pkg::br_kind_t ex_br_kind;
  rv_core_pkg::addr_t    ex_pc;
  // Execute to result
  logic                  wb_valid, wb_we;
  rv_core_pkg::reg_idx_t wb_rd;
  rv_core_pkg::xlen_t    wb_data;
  rv_core_pkg::addr_t    wb_pc;

  rv_fetch u_fetch (
    .clk_i, .rstn_i, .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .dec_ready_i(dec_ready), .imem_addr_o, .imem_rdata_i,
    .instr_o(f_instr), .pc_o(f_pc), .valid_o(f_valid)
  );

  rv_decode u_decode (
    .clk_i, .rstn_i, .hold_i, .instr_i(f_instr), .pc_i(f_pc), .valid_i(f_valid),
    .dec_ready_o(dec_ready), .rs1_o(rs1), .rs2_o(rs2),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex_busy_rd_i(ex_busy_rd), .ex_busy_i(ex_busy),
    .wb_busy_rd_i(wb_busy_rd), .wb_busy_i(wb_busy), .flush_i(redirect),
    .ex_valid_o(ex_valid), .alu_op_o(ex_alu_op), .opa_o(ex_opa), .opb_o(ex_opb),
    .imm_o(ex_imm), .rd_o(ex_rd), .rd_we_o(ex_rd_we), .br_kind_o(ex_br_kind), .pc_o(ex_pc)
  );

  rv_execute u_execute (
    .clk_i, .rstn_i, .ex_valid_i(ex_valid), .alu_op_i(ex_alu_op),
    .opa_i(ex_opa), .opb_i(ex_opb), .imm_i(ex_imm), .rd_i(ex_rd), .rd_we_i(ex_rd_we),
    .br_kind_i(ex_br_kind), .pc_i(ex_pc), .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .busy_o(ex_busy), .busy_rd_o(ex_busy_rd), .wb_valid_o(wb_valid), .wb_rd_o(wb_rd),
    .wb_we_o(wb_we), .wb_data_o(wb_data), .wb_pc_o(wb_pc)
  );

  rv_result u_result (
    .clk_i, .rstn_i, .wb_valid_i(wb_valid), .wb_rd_i(wb_rd), .wb_we_i(wb_we),
    .wb_data_i(wb_data), .wb_pc_i(wb_pc), .rs1_i(rs1), .rs2_i(rs2),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .busy_o(wb_busy), .busy_rd_o(wb_busy_rd),
    .retire_valid_o, .retire_pc_o, .retire_rd_o, .retire_data_o
  );

endmodule

//--- rv_core_props.sv
// Concurrent checks on the fetch to decode link and the redirect squash, bound into every decode
`timescale 1ns/100ps

module rv_core_props (
  input logic                clk_i,
  input logic                rstn_i,
  input logic                flush_i,      // Redirect pulse from execute
  input logic                valid_i,      // Fetch valid as seen by decode
  input logic                dec_ready_i,
  input rv_core_pkg::instr_t instr_i,
  input rv_core_pkg::addr_t  pc_i,
  input logic                ex_valid_i    // Decode output toward execute
);

  ////////////////////////////////////////
  // Fetch drops the two words in flight on the old path
  redirect_drop: assert property (@(posedge clk_i) disable iff (!rstn_i)
    flush_i |=> !valid_i [*2])
    else $error("Fetch valid rose within two cycles of a redirect");

  // Word on offer must not move while decode refuses it
  stall_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (valid_i && !dec_ready_i) |=> ($stable(instr_i) && $stable(pc_i)))
    else $error("Fetch word or pc changed during a decode stall");

  // Word behind a taken branch and both dropped fetches never reach execute
  flush_squash: assert property (@(posedge clk_i) disable iff (!rstn_i)
    flush_i |=> !ex_valid_i [*3])
    else $error("Decode issued an instruction within three cycles of a redirect");

endmodule

// Decode ports carry the whole fetch handshake as well
bind rv_decode rv_core_props u_props (
  .clk_i, .rstn_i, .flush_i, .valid_i, .instr_i, .pc_i,
  .dec_ready_i(dec_ready_o), .ex_valid_i(ex_valid_o)
);

//--- tb_rv_core.sv
// Testbench for the RV32I core, runs the program in prog_cases.txt twice and checks every retire
`timescale 1ns/100ps

module tb_rv_core;

  localparam int MEM_WORDS = 256;             // Instruction memory depth in words

  logic                  clk_i;
  logic                  rstn_i;
  logic                  hold_i;
  rv_core_pkg::addr_t    imem_addr_o;
  rv_core_pkg::instr_t   imem_rdata_i;
  logic                  retire_valid_o;
  rv_core_pkg::addr_t    retire_pc_o;
  rv_core_pkg::reg_idx_t retire_rd_o;
  rv_core_pkg::xlen_t    retire_data_o;

  rv_core_pkg::instr_t   mem [MEM_WORDS];
  logic [7:0]            mem_idx;             // Word index latched mid-cycle
  rv_core_pkg::addr_t    exp_pc [$];          // Expected retire stream
  rv_core_pkg::reg_idx_t exp_rd [$];
  rv_core_pkg::xlen_t    exp_data [$];
  rv_core_pkg::addr_t    run1_pc [$];         // Stream seen without hold
  rv_core_pkg::reg_idx_t run1_rd [$];
  rv_core_pkg::xlen_t    run1_data [$];
  logic [31:0]           lcg_state;
  int                    errors;
  int                    retired;
  int                    wd_cycles;

  rv_core_top dut_i (
    .clk_i, .rstn_i, .hold_i, .imem_addr_o, .imem_rdata_i,
    .retire_valid_o, .retire_pc_o, .retire_rd_o, .retire_data_o
  );

  always #2 clk_i = ~clk_i;                   // 4 ns period

  ////////////////////////////////////////
  // Memory model, data for an address shows up one cycle later
  always @(negedge clk_i) mem_idx = imem_addr_o[9:2];
  always @(posedge clk_i) begin
    #0.5 imem_rdata_i = mem[mem_idx];
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // P lines fill memory, R lines queue expected retires, # starts a comment
  task automatic load_cases();
    int               fd;
    int               c;
    int               n;
    logic [31:0]      a, b, d;
    logic [8*128-1:0] skip;
    fd = $fopen("prog_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open prog_cases.txt");
      errors++;
      return;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "P") begin
        n = $fscanf(fd, " %h %h", a, b);
        if (n != 2) begin
          $display("Malformed program line in prog_cases.txt");
          errors++;
        end
        mem[a[9:2]] = b;
      end else if (c == "R") begin
        n = $fscanf(fd, " %h %h %h", a, b, d);
        if (n != 3) begin
          $display("Malformed retire line in prog_cases.txt");
          errors++;
        end
        exp_pc.push_back(a);
        exp_rd.push_back(b[4:0]);
        exp_data.push_back(d);
      end else if (c == "#") begin
        n = $fgets(skip, fd);                 // Rest of the comment
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic check_retire(input int run_no, input int idx);
    if (retire_pc_o !== exp_pc[idx] || retire_rd_o !== exp_rd[idx] ||
        retire_data_o !== exp_data[idx]) begin
      $display("ERROR %0t: run %0d retire %0d got pc %h rd %0d data %h", $time, run_no, idx,
               retire_pc_o, retire_rd_o, retire_data_o);
      $display("  expected pc %h rd %0d data %h", exp_pc[idx], exp_rd[idx], exp_data[idx]);
      errors++;
    end
    if (run_no == 1) begin
      run1_pc.push_back(retire_pc_o);
      run1_rd.push_back(retire_rd_o);
      run1_data.push_back(retire_data_o);
    end else if (retire_pc_o !== run1_pc[idx] || retire_rd_o !== run1_rd[idx] ||
                 retire_data_o !== run1_data[idx]) begin
      $display("ERROR %0t: run %0d retire %0d differs from run 1", $time, run_no, idx);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // One reset and one pass over the expected retire stream
  task automatic run_program(input logic random_hold, input int run_no);
    int seen;
    seen = 0;
    if (run_no > 1) begin
      @(posedge clk_i);
      #0.5;
    end
    rstn_i = 1'b0;
    hold_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #0.5 rstn_i = 1'b1;
    @(negedge clk_i);
    if (imem_addr_o !== rv_core_pkg::BOOT_ADDR || retire_valid_o !== 1'b0) begin
      $display("ERROR %0t: run %0d after reset addr %h retire_valid %b", $time, run_no,
               imem_addr_o, retire_valid_o);
      errors++;
    end
    while (seen < exp_pc.size()) begin
      @(posedge clk_i);
      #0.5;
      if (random_hold) hold_i = ((next_random() >> 30) == 0);  // About one cycle in four
      @(negedge clk_i);
      if (retire_valid_o === 1'b1) begin
        check_retire(run_no, seen);
        seen++;
        retired++;
      end
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rstn_i       = 1'b0;
    hold_i       = 1'b0;
    imem_rdata_i = rv_core_pkg::NOP_INSTR;
    mem_idx      = '0;
    lcg_state    = 32'd60;
    errors       = 0;
    retired      = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[24:0], 7'b0001011};         // Custom-0 opcode, decodes as NOP
    end
    load_cases();
    if (exp_pc.size() == 0) begin
      $display("No expected retires were loaded");
      errors++;
    end else begin
      wd_cycles = 2 * (40 * exp_pc.size() + 5);
      run_program(1'b0, 1);
      run_program(1'b1, 2);
    end
    $display("Run complete, %0d retires checked, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog, budget grows with the number of expected retires
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_i);
    $display("Watchdog expired, the retire stream stalled after %0d retires", retired);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- compile.f
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
rv_core_props.sv
tb_rv_core.sv

//--- prog_cases.txt
# P lines hold a byte address and an instruction word, both hex
# R lines hold retire pc, rd and data in hex, in retire order
P 00000000 00500093  # addi x1, x0, 5
P 00000004 ffd08113  # addi x2, x1, -3
P 00000008 401101b3  # sub x3, x2, x1
P 0000000c 0011a233  # slt x4, x3, x1
P 00000010 123452b7  # lui x5, 0x12345
P 00000014 0ff2c313  # xori x6, x5, 0xff
P 00000018 004363b3  # or x7, x6, x4
P 0000001c 0f03f413  # andi x8, x7, 0xf0
P 00000020 00708013  # addi x0, x1, 7
P 00000024 00800463  # beq x0, x8, +8 not taken
P 00000028 00041463  # bne x8, x0, +8 taken
P 0000002c 00100493  # addi x9, x0, 1 skipped
P 00000030 00306533  # or x10, x0, x3
P 00000034 008005ef  # jal x11, +8
P 00000038 00200613  # addi x12, x0, 2 skipped
P 0000003c 00350463  # beq x10, x3, +8 taken
P 00000040 00300693  # addi x13, x0, 3 skipped
P 00000044 00258733  # add x14, x11, x2
P 00000048 003747b3  # xor x15, x14, x3
P 0000004c ffc1a813  # slti x16, x3, -4
P 00000050 7000e893  # ori x17, x1, 0x700
P 00000054 0071f933  # and x18, x3, x7
P 00000058 00109463  # bne x1, x1, +8 not taken
P 0000005c 0000006f  # jal x0, 0 parks the core
R 00000000 01 00000005
R 00000004 02 00000002
R 00000008 03 fffffffd
R 0000000c 04 00000001
R 00000010 05 12345000
R 00000014 06 123450ff
R 00000018 07 123450ff
R 0000001c 08 000000f0
R 00000020 00 00000000
R 00000024 00 00000000
R 00000028 00 00000000
R 00000030 0a fffffffd
R 00000034 0b 00000038
R 0000003c 00 00000000
R 00000044 0e 0000003a
R 00000048 0f ffffffc7
R 0000004c 10 00000000
R 00000050 11 00000705
R 00000054 12 123450fd
R 00000058 00 00000000
R 0000005c 00 00000000
